// ==== Bender.yml ====
package:
  name: conv_layer

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/conv_pkg.sv
      - design/line_buffer.sv
      - design/conv_window.sv
      - design/result_collector.sv
      - design/conv_layer_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/conv_layer_properties.sv
      - bench/conv_layer_checker.sv
      - bench/conv_layer_tb.sv

// ==== bench/conv_layer_checker.sv ====
module conv_layer_checker (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              quiet,      // outputs must idle in this phase
	input  logic              pix_ack,
	input  logic              out_req,
	input  conv_pkg::bundle_t out_bundle,
	output int                err_count,
	output int                got_count
);
	timeunit 1ns;
	timeprecision 1ps;
	import conv_pkg::*;

	bundle_t exp_q [$]; // expected bundles in raster order
	logic    req_q;     // out_req one sample back for edge detect

	// model side pushes here before the frame is sent
	task automatic push_expected(input bundle_t b);
		exp_q.push_back(b);
	endtask

	always @(posedge clk) begin : watch
		bundle_t exp_b;
		int      errs; // errors found this sample
		errs = 0;
		if (!rst_n) begin
			req_q     <= 1'b0;
			err_count <= 0;
			got_count <= 0;
		end else begin
			req_q <= out_req;

			// idle interface right after reset
			if (quiet && pix_ack) begin
				$display("ERROR pix_ack expected %h got %h", 1'b0, pix_ack);
				errs++;
			end
			if (quiet && out_req) begin
				$display("ERROR out_req expected %h got %h", 1'b0, out_req);
				errs++;
			end

			// one compare per offered bundle
			if (out_req && !req_q) begin
				got_count <= got_count + 1;
				if (exp_q.size() == 0) begin
					$display("bundle %h offered with none expected", out_bundle);
					errs++;
				end else begin
					exp_b = exp_q.pop_front();
					if (out_bundle !== exp_b) begin
						$display("ERROR out_bundle expected %h got %h", exp_b, out_bundle);
						errs++;
					end
				end
			end

			err_count <= err_count + errs;
		end
	end

endmodule

// ==== bench/conv_layer_properties.sv ====
module conv_layer_properties (
	input logic              clk,
	input logic              rst_n,
	input logic              pix_req,
	input logic              pix_ack,
	input conv_pkg::pixel_t  pix_data,
	input logic              out_req,
	input logic              out_ack,
	input conv_pkg::bundle_t out_bundle
);
	timeunit 1ns;
	timeprecision 1ps;
	import conv_pkg::*;

	int fail_count = 0; // read by the testbench for the verdict

	// source keeps the pixel until the line buffer has taken it
	pix_data_held: assert property (@(posedge clk) disable iff (!rst_n)
		pix_req && !pix_ack |=> $stable(pix_data))
		else begin
			fail_count++;
			$error("pix_data changed while pix_req waited for pix_ack");
		end

	// offered bundle stays up until the sink acks
	out_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		out_req && !out_ack |=> out_req)
		else begin
			fail_count++;
			$error("out_req dropped before out_ack rose");
		end

	out_bundle_held: assert property (@(posedge clk) disable iff (!rst_n)
		out_req && !out_ack |=> $stable(out_bundle))
		else begin
			fail_count++;
			$error("out_bundle changed while it was offered");
		end

	// four-phase return to zero before the next offer
	out_req_after_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(out_req) |-> !out_ack)
		else begin
			fail_count++;
			$error("out_req rose while out_ack was still high");
		end

endmodule

bind conv_layer_top conv_layer_properties props_inst (
	.clk        (clk),
	.rst_n      (rst_n),
	.pix_req    (pix_req),
	.pix_ack    (pix_ack),
	.pix_data   (pix_data),
	.out_req    (out_req),
	.out_ack    (out_ack),
	.out_bundle (out_bundle)
);

// ==== bench/conv_layer_tb.sv ====
`include "conv_defines.svh"

module conv_layer_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import conv_pkg::*;

	localparam int ACK_LIMIT   = 100; // cycles per pix_ack edge under back-pressure
	localparam int DRAIN_LIMIT = 400; // cycles for the last bundles of a frame

	logic    clk = 1'b0;
	logic    rst_n;
	logic    pix_req;
	pixel_t  pix_data;
	logic    pix_ack;
	filter_t filters [`N_ENGINES];
	logic    out_req;
	logic    out_ack = 1'b0;
	bundle_t out_bundle;
	logic    quiet;

	logic [15:0] lfsr;                    // stimulus stream
	logic [15:0] sink_lfsr = 16'd24882;   // ack delays on a separate stream
	int          sink_wait = -1;          // cycles left before ack or -1 when none drawn
	int          bench_errors = 0;
	int          expected_total = 0;
	int          chk_errors;
	int          got_count;
	pixel_t      img [`IMG_HEIGHT][`IMG_WIDTH];

	always #5 clk = ~clk;

	conv_layer_top conv_layer_top_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.pix_req    (pix_req),
		.pix_data   (pix_data),
		.pix_ack    (pix_ack),
		.filters    (filters),
		.out_req    (out_req),
		.out_ack    (out_ack),
		.out_bundle (out_bundle)
	);

	conv_layer_checker checker_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.quiet      (quiet),
		.pix_ack    (pix_ack),
		.out_req    (out_req),
		.out_bundle (out_bundle),
		.err_count  (chk_errors),
		.got_count  (got_count)
	);

	// taps 16 14 13 11 for maximal length
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr); // one step per bit
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// sink acks after 0..7 cycles and drops once req is gone
	always @(posedge clk) begin : sink
		logic req_now;
		logic rst_now;
		req_now = out_req;
		rst_now = rst_n;
		#1;
		if (!rst_now) begin
			out_ack = 1'b0;
			sink_wait = -1;
		end else if (req_now && !out_ack) begin
			if (sink_wait < 0) begin
				sink_wait = 0;
				for (int i = 0; i < 3; i++) begin
					sink_lfsr = lfsr_step(sink_lfsr);
					sink_wait = (sink_wait << 1) | sink_lfsr[0];
				end
			end
			if (sink_wait == 0) begin
				out_ack = 1'b1;
				sink_wait = -1;
			end else begin
				sink_wait--;
			end
		end else if (!req_now && out_ack) begin
			out_ack = 1'b0;
		end
	end

	task automatic finish_run();
		int total;
		total = chk_errors + bench_errors + conv_layer_top_inst.props_inst.fail_count;
		$display("done: %0d mismatches, %0d bench errors, %0d assert fails, %0d/%0d bundles",
			chk_errors, bench_errors, conv_layer_top_inst.props_inst.fail_count,
			got_count, expected_total);
		if (total == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	task automatic wait_ack(input logic level);
		int t;
		t = 0;
		do begin
			@(posedge clk);
			t++;
			if (t > ACK_LIMIT) begin
				$display("hang: pix_ack did not go %s", level ? "high" : "low");
				bench_errors++;
				finish_run();
			end
		end while (pix_ack !== level);
		#1; // back to the drive point
	endtask

	task automatic wait_bundles();
		int t;
		t = 0;
		while (got_count < expected_total) begin
			@(posedge clk);
			t++;
			if (t > DRAIN_LIMIT) begin
				$display("hang: out_req handshake stalled at %0d of %0d bundles",
					got_count, expected_total);
				bench_errors++;
				finish_run();
			end
		end
		if (t > 0) #1;
	endtask

	task automatic send_pixel(input pixel_t p);
		int gap;
		gap = take_bits(2); // 0..3 idle cycles
		repeat (gap) @(posedge clk);
		if (gap > 0) #1;
		pix_data = p;
		pix_req  = 1'b1;
		wait_ack(1'b1);
		pix_req  = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic set_filters(input bit extreme);
		for (int e = 0; e < `N_ENGINES; e++) begin
			for (int k = 0; k < 25; k++) begin
				if (extreme) begin
					filters[e][k] = (e % 2 == 0) ? 8'sd127 : -8'sd128; // even engines up
				end else begin
					filters[e][k] = coeff_t'(take_bits(8));
				end
			end
		end
	endtask

	// correlation over every full window then clamp
	task automatic model_frame();
		bundle_t b;
		pixel_t  p;
		coeff_t  w;
		int      acc;
		for (int y = 0; y <= `IMG_HEIGHT - 5; y++) begin
			for (int x = 0; x <= `IMG_WIDTH - 5; x++) begin
				for (int e = 0; e < `N_ENGINES; e++) begin
					acc = 0;
					for (int r = 0; r < 5; r++) begin
						for (int c = 0; c < 5; c++) begin
							p = img[y+r][x+c];
							w = filters[e][5*r+c];
							acc += int'(p) * int'(w);
						end
					end
					if (acc > 32767) acc = 32767;
					if (acc < -32768) acc = -32768;
					b[e] = result_t'(acc);
				end
				checker_inst.push_expected(b);
				expected_total++;
			end
		end
	endtask

	task automatic run_frame(input bit extreme);
		for (int y = 0; y < `IMG_HEIGHT; y++) begin
			for (int x = 0; x < `IMG_WIDTH; x++) begin
				if (extreme) begin
					img[y][x] = (take_bits(2) != 0) ? 8'sd127 : -8'sd128; // mostly +127
				end else begin
					img[y][x] = pixel_t'(take_bits(8));
				end
			end
		end
		model_frame(); // zero time so frames stay back to back
		for (int y = 0; y < `IMG_HEIGHT; y++) begin
			for (int x = 0; x < `IMG_WIDTH; x++) begin
				send_pixel(img[y][x]);
			end
		end
	endtask

	initial begin : stimulus
		pix_req  = 1'b0;
		pix_data = '0;
		quiet    = 1'b0;
		filters  = '{default: '0};
		lfsr     = 16'd24882;
		rst_n    = 1'b0;
		repeat (5) @(posedge clk);
		#1 rst_n = 1'b1;

		quiet = 1'b1; // nothing may move yet
		repeat (20) @(posedge clk);
		#1 quiet = 1'b0;

		set_filters(1'b0);
		run_frame(1'b0);
		wait_bundles();

		set_filters(1'b1); // saturation both ways
		run_frame(1'b1);
		wait_bundles();

		set_filters(1'b0);
		repeat (3) run_frame(1'b0);
		wait_bundles();

		repeat (50) @(posedge clk); // room for stray bundles
		#1;
		if (got_count != expected_total) begin
			$display("bundle count wrong: got %0d, expected %0d", got_count, expected_total);
			bench_errors++;
		end
		finish_run();
	end

endmodule

// ==== conv_layer.f ====
+incdir+design
design/conv_pkg.sv
design/line_buffer.sv
design/conv_window.sv
design/result_collector.sv
design/conv_layer_top.sv
bench/conv_layer_properties.sv
bench/conv_layer_checker.sv
bench/conv_layer_tb.sv

// ==== design/conv_defines.svh ====
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// pixel and coefficient width, signed
`define PIXEL_WIDTH 8

// saturated result width, signed
`define OUT_WIDTH 16

// plane size in pixels
`define IMG_WIDTH 12
`define IMG_HEIGHT 10

// parallel filters, one engine each
`define N_ENGINES 4

`endif

// ==== design/conv_layer_top.sv ====
`include "conv_defines.svh"

module conv_layer_top (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              pix_req,
	input  conv_pkg::pixel_t  pix_data,
	output logic              pix_ack,
	input  conv_pkg::filter_t filters [`N_ENGINES],
	output logic              out_req,
	input  logic              out_ack,
	output conv_pkg::bundle_t out_bundle
);
	import conv_pkg::*;

	logic                   shift_en;      // one pulse per accepted pixel
	column_t                col;
	logic                   win_valid;
	bundle_t                res_bundle;    // engine results side by side
	logic [`N_ENGINES-1:0]  res_valid_vec;
	logic                   busy;          // collector back-pressure

	line_buffer line_buffer_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.pix_req   (pix_req),
		.pix_data  (pix_data),
		.busy      (busy),
		.pix_ack   (pix_ack),
		.shift_en  (shift_en),
		.col       (col),
		.win_valid (win_valid)
	);

	// same column stream into every engine, own filter each
	for (genvar g = 0; g < `N_ENGINES; g++) begin : g_engine
		conv_window conv_window_inst (
			.clk       (clk),
			.rst_n     (rst_n),
			.shift_en  (shift_en),
			.win_valid (win_valid),
			.col       (col),
			.filter    (filters[g]),
			.res       (res_bundle[g]),
			.res_valid (res_valid_vec[g])
		);
	end

	// engines run in lockstep, engine 0 valid stands for all
	result_collector result_collector_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.res_valid  (res_valid_vec[0]),
		.res_in     (res_bundle),
		.out_ack    (out_ack),
		.out_req    (out_req),
		.out_bundle (out_bundle),
		.busy       (busy)
	);

endmodule

// ==== design/conv_pkg.sv ====
package conv_pkg;

	`include "conv_defines.svh"

	// one input sample
	typedef logic signed [`PIXEL_WIDTH-1:0] pixel_t;

	// one filter tap, same width as a pixel
	typedef logic signed [`PIXEL_WIDTH-1:0] coeff_t;

	// vertical slice of the 5x5 window
	// row0 is the oldest line (top), row4 the pixel just received
	typedef struct packed {
		pixel_t row0;
		pixel_t row1;
		pixel_t row2;
		pixel_t row3;
		pixel_t row4;
	} column_t;

	// 25 taps, row-major, tap 0 = top left in the low bits
	typedef coeff_t [24:0] filter_t;

	// saturated engine output
	typedef logic signed [`OUT_WIDTH-1:0] result_t;

	// one result per engine, engine 0 in the low bits
	typedef result_t [`N_ENGINES-1:0] bundle_t;

	// input side four-phase handshake
	typedef enum logic [1:0] {
		IDLE, // waiting for pix_req
		ACK,  // pixel taken, ack high until req falls
		DROP  // ack low again, one guard cycle
	} lb_state_e;

	// output side bundle register
	typedef enum logic [1:0] {
		EMPTY,  // nothing held
		OFFER,  // out_req high
		RETIRE  // sink acked, wait for ack to fall
	} out_state_e;

endpackage

// ==== design/conv_window.sv ====
`include "conv_defines.svh"

module conv_window (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              shift_en,
	input  logic              win_valid,
	input  conv_pkg::column_t col,
	input  conv_pkg::filter_t filter,
	output conv_pkg::result_t res,
	output logic              res_valid
);
	import conv_pkg::*;

	localparam int SUM_W      = 2 * `PIXEL_WIDTH + 5; // 25 products need 5 guard bits
	localparam int TREE_DEPTH = 5;                    // 25 13 7 4 2 1
	localparam int SAT_MAX    = 2 ** (`OUT_WIDTH - 1) - 1;
	localparam int SAT_MIN    = -(2 ** (`OUT_WIDTH - 1));

	pixel_t win     [5][5]; // [row][col], col 4 newest
	pixel_t win_nxt [5][5]; // window after the pending shift
	pixel_t col_px  [5];    // incoming column by row

	logic signed [SUM_W-1:0] lvl [TREE_DEPTH+1][25]; // adder tree levels
	logic signed [SUM_W-1:0] sum;
	result_t                 sat;

	assign col_px[0] = col.row0;
	assign col_px[1] = col.row1;
	assign col_px[2] = col.row2;
	assign col_px[3] = col.row3;
	assign col_px[4] = col.row4;

	// shift left by one column, new column enters on the right
	always_comb begin
		for (int r = 0; r < 5; r++) begin
			for (int c = 0; c < 4; c++) begin
				win_nxt[r][c] = win[r][c+1];
			end
			win_nxt[r][4] = col_px[r];
		end
	end

	// 25 products then pairwise reduction
	// sum is taken on the shifted view so the result lands with the shift
	always_comb begin
		int n; // live terms at the current level
		n   = 25;
		lvl = '{default: '0};
		for (int r = 0; r < 5; r++) begin
			for (int c = 0; c < 5; c++) begin
				lvl[0][5*r+c] = win_nxt[r][c] * filter[5*r+c]; // correlation, no flip
			end
		end
		for (int l = 0; l < TREE_DEPTH; l++) begin
			for (int i = 0; i < 12; i++) begin
				if (2 * i + 1 < n) begin
					lvl[l+1][i] = lvl[l][2*i] + lvl[l][2*i+1];
				end
			end
			if (n % 2 == 1) begin
				lvl[l+1][n/2] = lvl[l][n-1]; // odd term passes through
			end
			n = (n + 1) / 2;
		end
		sum = lvl[TREE_DEPTH][0];
	end

	// clamp to the signed output range
	always_comb begin
		if (sum > SAT_MAX) begin
			sat = result_t'(SAT_MAX);
		end else if (sum < SAT_MIN) begin
			sat = result_t'(SAT_MIN);
		end else begin
			sat = result_t'(sum);
		end
	end

	// window and result registers
	always_ff @(posedge clk) begin
		if (shift_en) begin
			win <= win_nxt;
			res <= sat; // held until the next pixel
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= win_valid; // one cycle behind, like res
		end
	end

endmodule

// ==== design/line_buffer.sv ====
`include "conv_defines.svh"

module line_buffer (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              pix_req,
	input  conv_pkg::pixel_t  pix_data,
	input  logic              busy,
	output logic              pix_ack,
	output logic              shift_en,
	output conv_pkg::column_t col,
	output logic              win_valid
);
	import conv_pkg::*;

	localparam int COL_W = $clog2(`IMG_WIDTH);
	localparam int ROW_W = $clog2(`IMG_HEIGHT);
	localparam logic [COL_W-1:0] LAST_COL = COL_W'(`IMG_WIDTH - 1);
	localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(`IMG_HEIGHT - 1);
	localparam int WIN_EDGE = 4; // first row/col index where a 5x5 window fits

	lb_state_e        state;
	logic [COL_W-1:0] col_cnt;  // x of the pixel being accepted
	logic [ROW_W-1:0] row_cnt;  // y of the pixel being accepted
	logic [1:0]       wr_sel;   // memory slot for the current row
	logic [1:0]       sel_m1;   // slot holding row y-1
	logic [1:0]       sel_m2;   // row y-2
	logic [1:0]       sel_m3;   // row y-3
	logic             accept;

	// circular history of the last four rows
	// slot wr_sel still holds row y-4 until overwritten
	pixel_t row_mem [4][`IMG_WIDTH];

	// take a pixel only when idle and nothing downstream is pending
	assign accept  = (state == IDLE) && pix_req && !busy;
	assign pix_ack = (state == ACK);

	assign sel_m1 = wr_sel - 2'd1; // wraps mod 4
	assign sel_m2 = wr_sel - 2'd2;
	assign sel_m3 = wr_sel - 2'd3;

	// four-phase input handshake
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:    if (accept) state <= ACK;
				ACK:     if (!pix_req) state <= DROP; // source released req
				DROP:    state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// raster position, row slot pointer, output pulses
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			shift_en  <= 1'b0;
			win_valid <= 1'b0;
			col_cnt   <= '0;
			row_cnt   <= '0;
			wr_sel    <= '0;
		end else begin
			shift_en  <= accept; // one pulse per pixel
			win_valid <= accept && (row_cnt >= WIN_EDGE) && (col_cnt >= WIN_EDGE);
			if (accept) begin
				if (col_cnt == LAST_COL) begin
					col_cnt <= '0;
					wr_sel  <= wr_sel + 2'd1; // next row goes to next slot
					if (row_cnt == LAST_ROW) begin
						row_cnt <= '0; // frame done, next one follows directly
					end else begin
						row_cnt <= row_cnt + 1'b1;
					end
				end else begin
					col_cnt <= col_cnt + 1'b1;
				end
			end
		end
	end

	// column assembly, reads see the old contents of this position
	always_ff @(posedge clk) begin
		if (accept) begin
			col.row0 <= row_mem[wr_sel][col_cnt]; // y-4
			col.row1 <= row_mem[sel_m3][col_cnt]; // y-3
			col.row2 <= row_mem[sel_m2][col_cnt]; // y-2
			col.row3 <= row_mem[sel_m1][col_cnt]; // y-1
			col.row4 <= pix_data;                 // current row

			// overwrite the oldest row at this x
			row_mem[wr_sel][col_cnt] <= pix_data;
		end
	end

endmodule

// ==== design/result_collector.sv ====
module result_collector (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              res_valid,
	input  conv_pkg::bundle_t res_in,
	input  logic              out_ack,
	output logic              out_req,
	output conv_pkg::bundle_t out_bundle,
	output logic              busy
);
	import conv_pkg::*;

	out_state_e state;
	logic       capture;

	// only an empty register can take a bundle
	// line buffer stalls on busy, so res_valid never hits a full register
	assign capture = (state == EMPTY) && res_valid;

	assign out_req = (state == OFFER);

	// covers the result on its way in and the held bundle
	assign busy = res_valid || (state != EMPTY);

	// four-phase output handshake
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= EMPTY;
		end else begin
			case (state)
				EMPTY: begin
					if (capture) begin
						state <= OFFER; // req rises next cycle
					end
				end
				OFFER: begin
					if (out_ack) begin
						state <= RETIRE; // drop req
					end
				end
				RETIRE: begin
					// no new req while the sink still acks
					if (!out_ack) begin
						state <= EMPTY;
					end
				end
				default: state <= EMPTY;
			endcase
		end
	end

	// bundle register, stable while offered
	always_ff @(posedge clk) begin
		if (capture) begin
			out_bundle <= res_in;
		end
	end

endmodule
